// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = mdc_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation failed
PASS_MSG  = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test: FAILED, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "test: no pass line in $(LOG)"; exit 1; }
	@echo "test: PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
+incdir+logic
logic/mdc_pkg.sv
logic/hamming_decoder.sv
logic/mdc_ctrl.sv
logic/mdc_minor_unit.sv
logic/mdc_expand_unit.sv
logic/mdc_top.sv
tb/mdc_tb.sv

// File: logic/hamming_decoder.sv
//==========================================================================
// single-error-correcting Hamming decoder, four parity bits at
// positions 1, 2, 4 and 8, returns the data bits only
//==========================================================================

`timescale 1ns/1ps

module hamming_decoder #(
    parameter int DATA_W = 11
) (
    input  logic [DATA_W+3:0] code,
    output logic [DATA_W-1:0] data
);

    localparam int CODE_W = DATA_W + 4;

    logic [3:0]        syndrome;
    logic [CODE_W-1:0] fixed;

    // position p lives at code bit CODE_W-p
    always_comb begin
        syndrome = '0;
        for (int p = 1; p <= CODE_W; p++) begin
            if (code[CODE_W-p]) begin
                syndrome = syndrome ^ 4'(p);
            end
        end
    end

    // flip the erroneous position, if any
    always_comb begin
        fixed = code;
        if (syndrome != 4'd0 && int'(syndrome) <= CODE_W) begin
            fixed[CODE_W-int'(syndrome)] = ~code[CODE_W-int'(syndrome)];
        end
    end

    // data bits in rising position order, first one is the MSB
    always_comb begin
        int k;
        k = DATA_W - 1;
        data = '0;
        for (int p = 1; p <= CODE_W; p++) begin
            if ((p & (p - 1)) != 0) begin
                data[k] = fixed[CODE_W-p];
                k = k - 1;
            end
        end
    end

endmodule

// File: logic/mdc_ctrl.sv
//==========================================================================
// burst controller: input FSM, entry store, mode capture, sequencing of
// the minor and expansion units, registered result word
//==========================================================================

`timescale 1ns/1ps

`include "mdc_params.svh"

module mdc_ctrl import mdc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  elem_t    data,
    input  mode_e    mode_in,
    input  minors_t  minors,
    input  logic     minor_done,
    input  det_t     det,
    input  logic     det_done,
    output matrix_t  matrix,
    output mode_e    mode,
    output logic     minor_start,
    output logic     expand_start,
    output logic     out_valid,
    output mdc_out_u out_data
);

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        WAIT
    } state_e;

    localparam logic [3:0] LAST_BEAT = 4'(`MDC_N_ENTRIES - 1);

    state_e     state;
    logic [3:0] beat_cnt;
    logic       supported;

    assign supported = (mode == SIZE2) || (mode == SIZE4);

    // entries enter at the top and move down, a11 ends at index 0
    always_ff @(posedge clk) begin
        if (in_valid && state != WAIT) begin
            matrix <= {data, matrix[`MDC_N_ENTRIES-1:1]};
        end
    end

    //======================================================================
    // FSM and result register
    //======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            beat_cnt     <= '0;
            mode         <= SIZE2;
            minor_start  <= 1'b0;
            expand_start <= 1'b0;
            out_valid    <= 1'b0;
            out_data     <= '0;
        end else begin
            minor_start  <= 1'b0;
            expand_start <= 1'b0;
            out_valid    <= 1'b0;
            out_data     <= '0;
            case (state)
                IDLE: begin
                    // first beat carries the mode
                    if (in_valid) begin
                        mode     <= mode_in;
                        beat_cnt <= 4'd1;
                        state    <= LOAD;
                    end
                end
                LOAD: begin
                    if (in_valid) begin
                        beat_cnt <= beat_cnt + 4'd1;
                        if (beat_cnt == LAST_BEAT) begin
                            if (supported) begin
                                minor_start <= 1'b1;
                                state       <= WAIT;
                            end else begin
                                // unknown or size-3 mode, zero result
                                out_valid <= 1'b1;
                                state     <= IDLE;
                            end
                        end
                    end
                end
                WAIT: begin
                    if (minor_done) begin
                        if (mode == SIZE4) begin
                            expand_start <= 1'b1;
                        end else begin
                            out_valid       <= 1'b1;
                            out_data.minors <= minors;
                            state           <= IDLE;
                        end
                    end
                    if (det_done) begin
                        out_valid                  <= 1'b1;
                        out_data.det_word.sign_ext <=
                            {(`MDC_OUT_W - `MDC_DET_W){det[`MDC_DET_W-1]}};
                        out_data.det_word.det      <= det;
                        state                      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: logic/mdc_expand_unit.sv
//==========================================================================
// Laplace expansion: row-2 cofactors from the bottom minors, then the
// 4x4 determinant along row 1
//==========================================================================

`timescale 1ns/1ps

module mdc_expand_unit import mdc_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  matrix_t matrix,
    input  minors_t minors,
    output det_t    det,
    output logic    done
);

    logic               busy;
    logic [2:0]         step_cnt;
    logic [2:0]         step;
    logic [1:0]         col1;
    logic [1:0]         col2;
    logic [1:0]         col3;
    logic [3:0]         mi1;
    logic [3:0]         mi2;
    logic [3:0]         mi3;
    logic signed [33:0] p1;
    logic signed [33:0] p2;
    logic signed [33:0] p3;
    cof_t               cof_sum;
    cof_t               cof [4];
    logic signed [44:0] term;

    assign step = start ? 3'd0 : step_cnt;

    // minor index: 0=12 1=13 2=14 3=23 4=24 5=34 (bottom-row columns)
    always_comb begin
        case (step[1:0])
            2'd0: begin
                col1 = 2'd1; col2 = 2'd2; col3 = 2'd3;
                mi1  = 4'd5; mi2  = 4'd4; mi3  = 4'd3;
            end
            2'd1: begin
                col1 = 2'd0; col2 = 2'd2; col3 = 2'd3;
                mi1  = 4'd5; mi2  = 4'd2; mi3  = 4'd1;
            end
            2'd2: begin
                col1 = 2'd0; col2 = 2'd1; col3 = 2'd3;
                mi1  = 4'd4; mi2  = 4'd2; mi3  = 4'd0;
            end
            default: begin
                col1 = 2'd0; col2 = 2'd1; col3 = 2'd2;
                mi1  = 4'd3; mi2  = 4'd1; mi3  = 4'd0;
            end
        endcase
    end

    // three-term MAC along row 2 of the 3x3 submatrix
    assign p1      = matrix[{2'd1, col1}] * minors[mi1];
    assign p2      = matrix[{2'd1, col2}] * minors[mi2];
    assign p3      = matrix[{2'd1, col3}] * minors[mi3];
    assign cof_sum = p1 - p2 + p3;

    // a1j times its 3x3 minor
    assign term = matrix[step[1:0]] * cof[step[1:0]];

    //======================================================================
    // step counter, eight steps
    //======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start || busy) begin
                if (step == 3'd7) begin
                    busy     <= 1'b0;
                    step_cnt <= '0;
                    done     <= 1'b1;
                end else begin
                    busy     <= 1'b1;
                    step_cnt <= step + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            if (!step[2]) begin
                cof[step[1:0]] <= cof_sum;
            end else if (step[1:0] == 2'd0) begin
                det <= term;
            end else if (step[0]) begin
                // odd columns carry a negative sign
                det <= det - term;
            end else begin
                det <= det + term;
            end
        end
    end

endmodule

// File: logic/mdc_minor_unit.sv
//==========================================================================
// 2x2 minor engine, one minor per cycle from one multiplier pair and
// one subtractor
//==========================================================================

`timescale 1ns/1ps

`include "mdc_params.svh"

module mdc_minor_unit import mdc_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  mode_e   mode,
    input  matrix_t matrix,
    output minors_t minors,
    output logic    done
);

    logic               busy;
    logic [3:0]         step_cnt;
    logic [3:0]         step;
    logic [3:0]         last_step;
    logic [1:0]         row;
    logic [1:0]         row_b;
    logic [1:0]         col_a;
    logic [1:0]         col_b;
    elem_t              op_a;
    elem_t              op_b;
    elem_t              op_c;
    elem_t              op_d;
    logic signed [21:0] prod_ad;
    logic signed [21:0] prod_bc;
    minor_t             diff;

    // first step runs in the start cycle
    assign step      = start ? 4'd0 : step_cnt;
    assign last_step = (mode == SIZE4) ? 4'd5 : 4'(`MDC_N_MINORS - 1);

    // operand rows and columns per step
    always_comb begin
        if (mode == SIZE4) begin
            // bottom rows, column pairs 12 13 14 23 24 34
            row = 2'd2;
            case (step)
                4'd0:    begin col_a = 2'd0; col_b = 2'd1; end
                4'd1:    begin col_a = 2'd0; col_b = 2'd2; end
                4'd2:    begin col_a = 2'd0; col_b = 2'd3; end
                4'd3:    begin col_a = 2'd1; col_b = 2'd2; end
                4'd4:    begin col_a = 2'd1; col_b = 2'd3; end
                default: begin col_a = 2'd2; col_b = 2'd3; end
            endcase
        end else begin
            row   = 2'(step / 4'd3);
            col_a = 2'(step % 4'd3);
            col_b = col_a + 2'd1;
        end
    end

    assign row_b = row + 2'd1;

    assign op_a = matrix[{row, col_a}];
    assign op_b = matrix[{row, col_b}];
    assign op_c = matrix[{row_b, col_a}];
    assign op_d = matrix[{row_b, col_b}];

    assign prod_ad = op_a * op_d;
    assign prod_bc = op_b * op_c;
    assign diff    = prod_ad - prod_bc;

    //======================================================================
    // step counter
    //======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start || busy) begin
                if (step == last_step) begin
                    busy     <= 1'b0;
                    step_cnt <= '0;
                    done     <= 1'b1;
                end else begin
                    busy     <= 1'b1;
                    step_cnt <= step + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            minors[step] <= diff;
        end
    end

endmodule

// File: logic/mdc_params.svh
//==========================================================================
// widths, burst sizes and mode codes of the determinant calculator
//==========================================================================

`ifndef MDC_PARAMS_SVH
`define MDC_PARAMS_SVH

// entry and codeword widths
`define MDC_ELEM_W          11
`define MDC_DATA_CODE_W     15
`define MDC_MODE_W          5
`define MDC_MODE_CODE_W     9

// arithmetic result widths
`define MDC_MINOR_W         23
`define MDC_COF_W           34
`define MDC_DET_W           45
`define MDC_OUT_W           207

// burst and result counts
`define MDC_N_ENTRIES       16
`define MDC_N_MINORS        9

// mode codes, size-3 is only recognised to be rejected
`define MDC_MODE_SIZE2      5'b00100
`define MDC_MODE_SIZE3      5'b00110
`define MDC_MODE_SIZE4      5'b10110

`endif

// File: logic/mdc_pkg.sv
//==========================================================================
// shared types: entries, matrix, minors, cofactors, determinant, modes
// and the two views of the output word
//==========================================================================

`include "mdc_params.svh"

package mdc_pkg;

    // one matrix entry
    typedef logic signed [`MDC_ELEM_W-1:0] elem_t;

    typedef enum logic [`MDC_MODE_W-1:0] {
        SIZE2 = `MDC_MODE_SIZE2,
        SIZE3 = `MDC_MODE_SIZE3,
        SIZE4 = `MDC_MODE_SIZE4
    } mode_e;

    // row-major, index 0 holds a11
    typedef elem_t [`MDC_N_ENTRIES-1:0] matrix_t;

    typedef logic signed [`MDC_MINOR_W-1:0] minor_t;

    // index 0 is minor 1 and sits in the top bits
    typedef minor_t [0:`MDC_N_MINORS-1] minors_t;

    typedef logic signed [`MDC_COF_W-1:0] cof_t;

    typedef logic signed [`MDC_DET_W-1:0] det_t;

    //======================================================================
    // output word
    //======================================================================
    typedef struct packed {
        logic [`MDC_OUT_W-`MDC_DET_W-1:0] sign_ext;
        det_t                             det;
    } det_word_t;

    // size-2 reads nine minors, size-4 reads one wide determinant
    typedef union packed {
        minors_t   minors;
        det_word_t det_word;
    } mdc_out_u;

endpackage

// File: logic/mdc_top.sv
//==========================================================================
// determinant calculator top: codeword decoders, burst controller,
// minor engine and expansion unit
//==========================================================================

`timescale 1ns/1ps

`include "mdc_params.svh"

module mdc_top import mdc_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  logic [`MDC_DATA_CODE_W-1:0] in_data,
    input  logic [`MDC_MODE_CODE_W-1:0] in_mode,
    output logic                        out_valid,
    output logic [`MDC_OUT_W-1:0]       out_data
);

    logic [`MDC_MODE_W-1:0] mode_dec;
    elem_t                  data_dec;
    mode_e                  mode_in;
    mode_e                  mode;
    matrix_t                matrix;
    minors_t                minors;
    det_t                   det;
    logic                   minor_start;
    logic                   minor_done;
    logic                   expand_start;
    logic                   det_done;

    hamming_decoder #(.DATA_W(`MDC_MODE_W)) u_mode_dec (
        .code (in_mode),
        .data (mode_dec)
    );

    hamming_decoder #(.DATA_W(`MDC_ELEM_W)) u_data_dec (
        .code (in_data),
        .data (data_dec)
    );

    // codes outside the enum stay as they are and are rejected later
    assign mode_in = mode_e'(mode_dec);

    mdc_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .data         (data_dec),
        .mode_in      (mode_in),
        .minors       (minors),
        .minor_done   (minor_done),
        .det          (det),
        .det_done     (det_done),
        .matrix       (matrix),
        .mode         (mode),
        .minor_start  (minor_start),
        .expand_start (expand_start),
        .out_valid    (out_valid),
        .out_data     (out_data)
    );

    mdc_minor_unit u_minor (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (minor_start),
        .mode   (mode),
        .matrix (matrix),
        .minors (minors),
        .done   (minor_done)
    );

    mdc_expand_unit u_expand (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (expand_start),
        .matrix (matrix),
        .minors (minors),
        .det    (det),
        .done   (det_done)
    );

endmodule

// File: tb/mdc_tb.sv
//==========================================================================
// directed testbench for the determinant calculator: Hamming encoder,
// reference minors and determinant, burst tests, result compare tasks
//==========================================================================

`timescale 1ns/1ps

`include "mdc_params.svh"

module mdc_tb import mdc_pkg::*; ();

    localparam int N_BURSTS       = 25;
    localparam int TIMEOUT_CYCLES = 40 * N_BURSTS;
    localparam int WAIT_LIMIT     = 30;
    localparam int MAX_LATENCY    = 20;

    logic                        clk;
    logic                        rst_n;
    logic                        in_valid;
    logic [`MDC_DATA_CODE_W-1:0] in_data;
    logic [`MDC_MODE_CODE_W-1:0] in_mode;
    logic                        out_valid;
    logic [`MDC_OUT_W-1:0]       out_data;

    int errors;
    int checks;
    int bursts_done;
    int pulse_cnt;
    int cycle_cnt;

    // single-bit error masks applied to the next burst
    logic [`MDC_DATA_CODE_W-1:0] data_mask [`MDC_N_ENTRIES];
    logic [`MDC_MODE_CODE_W-1:0] mode_mask;

    mdc_top u_mdc_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_mode   (in_mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // out_data must stay zero outside the valid cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid === 1'b1) begin
                pulse_cnt = pulse_cnt + 1;
            end else if (out_data !== '0) begin
                errors = errors + 1;
                $display("FAIL @%0t: out_data %h while out_valid is low", $time, out_data);
            end
        end
    end

    //======================================================================
    // encoder and reference model
    //======================================================================
    // data bits fill the non-power-of-two positions, MSB first
    function automatic logic [14:0] hamming_encode(input logic [10:0] d, input int dw);
        logic [14:0] c;
        logic        p;
        int          n;
        int          k;
        n = dw + 4;
        k = dw - 1;
        c = '0;
        for (int pos = 1; pos <= n; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                c[n-pos] = d[k];
                k = k - 1;
            end
        end
        for (int i = 0; i < 4; i++) begin
            p = 1'b0;
            for (int pos = 1; pos <= n; pos++) begin
                if (((pos >> i) & 1) == 1 && pos != (1 << i)) begin
                    p = p ^ c[n-pos];
                end
            end
            c[n-(1 << i)] = p;
        end
        return c;
    endfunction

    function automatic int rand_elem();
        elem_t e;
        e = elem_t'($urandom);
        return int'(e);
    endfunction

    // rule of Sarrus
    function automatic longint det3(input longint a, b, c, d, e, f, g, h, i);
        return a * e * i + b * f * g + c * d * h - c * e * g - b * d * i - a * f * h;
    endfunction

    function automatic longint reference_det(input int a [`MDC_N_ENTRIES]);
        longint sum;
        int     c [3];
        int     n;
        sum = 0;
        for (int j = 0; j < 4; j++) begin
            n = 0;
            for (int col = 0; col < 4; col++) begin
                if (col != j) begin
                    c[n] = col;
                    n = n + 1;
                end
            end
            // expansion along the first row
            sum += ((j % 2 == 0) ? 1 : -1) * longint'(a[j]) *
                   det3(a[4+c[0]], a[4+c[1]], a[4+c[2]],
                        a[8+c[0]], a[8+c[1]], a[8+c[2]],
                        a[12+c[0]], a[12+c[1]], a[12+c[2]]);
        end
        return sum;
    endfunction

    function automatic minors_t adjacent_minors(input int a [`MDC_N_ENTRIES]);
        minors_t m;
        int      r;
        int      c;
        for (int k = 1; k <= `MDC_N_MINORS; k++) begin
            r = (k - 1) / 3;
            c = (k - 1) % 3;
            m[k-1] = minor_t'(longint'(a[r*4+c]) * a[(r+1)*4+c+1]
                              - longint'(a[r*4+c+1]) * a[(r+1)*4+c]);
        end
        return m;
    endfunction

    //======================================================================
    // compare tasks
    //======================================================================
    task automatic check_minors(input minors_t got, input minors_t exp, input string tag);
        for (int k = 0; k < `MDC_N_MINORS; k++) begin
            checks = checks + 1;
            if (got[k] !== exp[k]) begin
                errors = errors + 1;
                $display("FAIL @%0t: %s minor %0d got %0d expected %0d",
                         $time, tag, k + 1, got[k], exp[k]);
            end
        end
    endtask

    task automatic check_det(input det_t got, input det_t exp, input string tag);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAIL @%0t: %s det got %0d expected %0d", $time, tag, got, exp);
        end
    endtask

    task automatic verify_sign_ext(input det_word_t w, input logic neg, input string tag);
        checks = checks + 1;
        if (w.sign_ext !== {(`MDC_OUT_W - `MDC_DET_W){neg}}) begin
            errors = errors + 1;
            $display("FAIL @%0t: %s upper bits %h do not extend the sign",
                     $time, tag, w.sign_ext);
        end
    endtask

    task automatic expect_zero_word(input mdc_out_u got, input string tag);
        checks = checks + 1;
        if (got !== '0) begin
            errors = errors + 1;
            $display("FAIL @%0t: %s result %h expected all zero", $time, tag, got);
        end
    endtask

    //======================================================================
    // burst driver
    //======================================================================
    task automatic clear_masks();
        for (int i = 0; i < `MDC_N_ENTRIES; i++) begin
            data_mask[i] = '0;
        end
        mode_mask = '0;
    endtask

    task automatic drive_burst(input int a [`MDC_N_ENTRIES], input logic [4:0] mode_code,
                               output mdc_out_u result);
        logic [14:0] mode_word;
        int          waited;
        mode_word = hamming_encode(11'(mode_code), `MDC_MODE_W);
        for (int i = 0; i < `MDC_N_ENTRIES; i++) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_data  = hamming_encode(11'(a[i]), `MDC_ELEM_W) ^ data_mask[i];
            // later beats carry junk on in_mode
            in_mode  = (i == 0) ? (mode_word[8:0] ^ mode_mask) : 9'($urandom);
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_data  = '0;
        in_mode  = '0;
        waited   = 0;
        while (out_valid !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited = waited + 1;
        end
        result      = out_data;
        bursts_done = bursts_done + 1;
        if (out_valid !== 1'b1) begin
            errors = errors + 1;
            $display("out_valid never came within %0d cycles of the last beat", WAIT_LIMIT);
        end else if (waited > MAX_LATENCY) begin
            errors = errors + 1;
            $display("out_valid came %0d cycles after the last beat, too late", waited);
        end
    endtask

    task automatic run_size2_case(input int a [`MDC_N_ENTRIES], input string tag);
        mdc_out_u res;
        drive_burst(a, `MDC_MODE_SIZE2, res);
        check_minors(res.minors, adjacent_minors(a), tag);
    endtask

    task automatic run_size4_case(input int a [`MDC_N_ENTRIES], input string tag);
        mdc_out_u res;
        longint   ref_val;
        ref_val = reference_det(a);
        drive_burst(a, `MDC_MODE_SIZE4, res);
        check_det(res.det_word.det, det_t'(ref_val), tag);
        // upper bits follow the sign of the full reference value
        verify_sign_ext(res.det_word, ref_val < 0, tag);
    endtask

    //======================================================================
    // directed tests
    //======================================================================
    task automatic size2_random_bursts(input int n);
        int a [`MDC_N_ENTRIES];
        for (int b = 0; b < n; b++) begin
            for (int i = 0; i < `MDC_N_ENTRIES; i++) begin
                a[i] = rand_elem();
            end
            run_size2_case(a, "size2 random");
        end
    endtask

    task automatic size4_fixed_matrices();
        int a [`MDC_N_ENTRIES];
        for (int i = 0; i < `MDC_N_ENTRIES; i++) begin
            a[i] = (i / 4 == i % 4) ? 1 : 0;
        end
        run_size4_case(a, "size4 identity");
        // last row repeats the first
        for (int i = 0; i < `MDC_N_ENTRIES; i++) begin
            a[i] = (i < 12) ? rand_elem() : a[i-12];
        end
        run_size4_case(a, "size4 singular");
    endtask

    task automatic size4_random_bursts(input int n);
        int a [`MDC_N_ENTRIES];
        for (int b = 0; b < n; b++) begin
            for (int i = 0; i < `MDC_N_ENTRIES; i++) begin
                a[i] = rand_elem();
            end
            run_size4_case(a, "size4 random");
        end
    endtask

    task automatic corrected_bit_flips();
        int a [`MDC_N_ENTRIES];
        for (int b = 0; b < `MDC_MODE_CODE_W; b++) begin
            for (int i = 0; i < `MDC_N_ENTRIES; i++) begin
                a[i]         = rand_elem();
                data_mask[i] = 15'(1) << ((b + i) % `MDC_DATA_CODE_W);
            end
            mode_mask = 9'(1) << b;
            if (b % 2 == 0) begin
                run_size2_case(a, "size2 bit flip");
            end else begin
                run_size4_case(a, "size4 bit flip");
            end
        end
        clear_masks();
    endtask

    task automatic extreme_entries();
        int a [`MDC_N_ENTRIES];
        // Sylvester Hadamard sign pattern, near the largest determinant
        for (int i = 0; i < `MDC_N_ENTRIES; i++) begin
            a[i] = ($countones((i / 4) & (i % 4)) % 2 == 0) ? 1023 : -1024;
        end
        run_size4_case(a, "size4 extreme pattern");
        for (int i = 0; i < `MDC_N_ENTRIES; i++) begin
            a[i] = ($countones((i / 4) & (i % 4)) % 2 == 0) ? -1024 : 1023;
        end
        run_size4_case(a, "size4 extreme inverted");
        for (int i = 0; i < `MDC_N_ENTRIES; i++) begin
            a[i] = ($urandom % 2 == 0) ? 1023 : -1024;
        end
        run_size4_case(a, "size4 extreme random");
    endtask

    task automatic rejected_modes();
        int         a [`MDC_N_ENTRIES];
        logic [4:0] codes [3];
        mdc_out_u   res;
        codes[0] = `MDC_MODE_SIZE3;
        codes[1] = 5'b11111;
        codes[2] = 5'b00000;
        for (int m = 0; m < 3; m++) begin
            for (int i = 0; i < `MDC_N_ENTRIES; i++) begin
                a[i] = rand_elem();
            end
            drive_burst(a, codes[m], res);
            expect_zero_word(res, $sformatf("mode %b", codes[m]));
            // no second pulse may follow
            for (int w = 0; w < 25; w++) begin
                @(negedge clk);
                if (out_valid === 1'b1) begin
                    errors = errors + 1;
                    $display("mode %b gave a second out_valid pulse", codes[m]);
                end
            end
        end
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        bursts_done = 0;
        pulse_cnt   = 0;
        cycle_cnt   = 0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        in_mode     = '0;
        clear_masks();
        void'($urandom(32'h358c2891));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        size2_random_bursts(4);
        size4_fixed_matrices();
        size4_random_bursts(4);
        corrected_bit_flips();
        extreme_entries();
        rejected_modes();

        repeat (4) @(negedge clk);
        if (pulse_cnt != bursts_done) begin
            errors = errors + 1;
            $display("saw %0d out_valid cycles for %0d bursts", pulse_cnt, bursts_done);
        end
        $display("bursts: %0d  checks: %0d  errors: %0d", bursts_done, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
